/* files.f */
verilog/lsu_pkg.sv
verilog/pipe_pkg.sv
verilog/store_align.sv
verilog/data_ram.sv
verilog/load_extend.sv
verilog/wb_reg.sv
verilog/mem_wb_stage.sv
verification/tb_mem_wb_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it into sim.log and grep the log for the result.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_mem_wb_stage \
    -f files.f -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Test failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

/* verification/tb_mem_wb_stage.sv */
`timescale 1ns/1ps

module tb_mem_wb_stage;
    import lsu_pkg::*;
    import pipe_pkg::*;

    localparam int RAM_WORDS  = 256;
    localparam int CLK_PERIOD = 100;
    localparam int RESET_WAIT = 40; // cycles allowed until reset release.

    logic      clk;
    logic      arst_n_i;
    stage_in_t stage_i;
    wb_bus_t   wb_o;

    logic [7:0] mem_model [int]; // byte model, keyed by byte address.
    wb_bus_t    exp_q [$];       // writebacks in flight.
    int         errors;
    int         checks;
    int         seed;

    mem_wb_stage #(
        .RAM_WORDS (RAM_WORDS)
    ) mem_wb_stage_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stage_i  (stage_i),
        .wb_o     (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD/2) clk = ~clk;
        end
    end

    initial begin
        arst_n_i = 1'b0;
        repeat (10) @(posedge clk);
        arst_n_i <= 1'b1;
    end

    function automatic logic [7:0] read_byte(word_t addr);
        if (mem_model.exists(int'(addr))) begin
            return mem_model[int'(addr)];
        end
        return 8'h00;
    endfunction

    // RV32 load semantics over the byte model.
    function automatic word_t model_load(load_type_e t, word_t addr);
        logic [7:0]  b;
        logic [15:0] h;
        b = read_byte(addr);
        h = {read_byte(addr + 32'd1), b};
        case (t)
            LOAD_LB:  return {{24{b[7]}}, b};
            LOAD_LBU: return {24'd0, b};
            LOAD_LH:  return {{16{h[15]}}, h};
            LOAD_LHU: return {16'd0, h};
            LOAD_LW:  return {read_byte(addr + 32'd3), read_byte(addr + 32'd2), h};
            default:  return 32'd0;
        endcase
    endfunction

    function automatic void model_store(store_type_e t, word_t addr, word_t data);
        int n;
        case (t)
            STORE_SB: n = 1;
            STORE_SH: n = 2;
            STORE_SW: n = 4;
            default:  n = 0;
        endcase
        for (int i = 0; i < n; i++) begin
            mem_model[int'(addr) + i] = data[i*8 +: 8];
        end
    endfunction

    function automatic stage_in_t make_instr(logic rd_wen, logic [4:0] rd_idx, word_t alu,
                                             word_t sdata, load_type_e lt, store_type_e st);
        stage_in_t s;
        s.rd_wen     = rd_wen;
        s.rd_idx     = rd_idx;
        s.alu_result = alu;
        s.store_data = sdata;
        s.load_type  = lt;
        s.store_type = st;
        s.mem_wen    = (st != STORE_NONE);
        s.csr_wdata  = $random(seed);
        return s;
    endfunction

    task automatic check_field(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected %08h actual %08h",
                     $time, name, exp, act);
        end
    endtask

    task automatic check_oldest();
        wb_bus_t e;
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            check_field("wb_o.wen", word_t'(e.wen), word_t'(wb_o.wen));
            check_field("wb_o.rd_idx", word_t'(e.rd_idx), word_t'(wb_o.rd_idx));
            check_field("wb_o.wdata", e.wdata, wb_o.wdata);
            check_field("wb_o.csr_wdata", e.csr_wdata, wb_o.csr_wdata);
        end
    endtask

    // drive one instruction and check the one issued a cycle before.
    task automatic issue(input stage_in_t s);
        wb_bus_t e;
        e.wen       = s.rd_wen;
        e.rd_idx    = s.rd_idx;
        e.wdata     = (s.load_type != LOAD_NONE) ? model_load(s.load_type, s.alu_result)
                                                 : s.alu_result;
        e.csr_wdata = s.csr_wdata;
        if (s.mem_wen) begin
            model_store(s.store_type, s.alu_result, s.store_data);
        end
        @(posedge clk);
        stage_i <= s;
        @(negedge clk);
        check_oldest();
        exp_q.push_back(e);
    endtask

    task automatic drain();
        @(posedge clk);
        stage_i <= '0;
        @(negedge clk);
        check_oldest();
    endtask

    task automatic test_reset(output bit ok);
        int        waited;
        stage_in_t busy;
        wb_bus_t   e;
        waited = 0;
        ok     = 1'b1;
        busy   = make_instr(1'b1, 5'd31, 32'hffff_fffc, 32'd0, LOAD_NONE, STORE_NONE);
        @(posedge clk);
        stage_i <= busy; // must not reach wb_o while reset is low.
        while (arst_n_i !== 1'b1 && waited < RESET_WAIT) begin
            @(negedge clk);
            check_field("wb_o.wen", 32'd0, word_t'(wb_o.wen));
            check_field("wb_o.wdata", 32'd0, wb_o.wdata);
            waited++;
        end
        if (arst_n_i !== 1'b1) begin
            errors++;
            ok = 1'b0;
            $display("timeout: reset was not released within %0d cycles", RESET_WAIT);
        end else begin
            // first edge out of reset captures the busy input.
            e.wen       = busy.rd_wen;
            e.rd_idx    = busy.rd_idx;
            e.wdata     = busy.alu_result;
            e.csr_wdata = busy.csr_wdata;
            exp_q.push_back(e);
            drain();
        end
    endtask

    task automatic test_alu_writeback();
        word_t r;
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            issue(make_instr(r[0], r[5:1], $random(seed), 32'd0, LOAD_NONE, STORE_NONE));
        end
        drain();
    endtask

    task automatic test_word_store_load();
        issue(make_instr(1'b1, 5'd7, 32'h0000_0040, 32'hdead_beef, LOAD_NONE, STORE_SW));
        issue(make_instr(1'b1, 5'd8, 32'h0000_0040, 32'd0, LOAD_LW, STORE_NONE));
        drain();
    endtask

    task automatic test_partial_stores();
        word_t base;
        base = 32'h0000_0080;
        for (int off = 0; off < 4; off++) begin
            issue(make_instr(1'b0, 5'd0, base, 32'h1122_3344, LOAD_NONE, STORE_SW));
            issue(make_instr(1'b0, 5'd0, base + word_t'(off), $random(seed),
                             LOAD_NONE, STORE_SB));
            issue(make_instr(1'b1, 5'd9, base, 32'd0, LOAD_LW, STORE_NONE));
        end
        for (int off = 0; off < 4; off += 2) begin
            issue(make_instr(1'b0, 5'd0, base, 32'h5566_7788, LOAD_NONE, STORE_SW));
            issue(make_instr(1'b0, 5'd0, base + word_t'(off), $random(seed),
                             LOAD_NONE, STORE_SH));
            issue(make_instr(1'b1, 5'd10, base, 32'd0, LOAD_LW, STORE_NONE));
        end
        drain();
    endtask

    task automatic test_load_extend();
        word_t base;
        word_t pattern;
        base = 32'h0000_0100;
        for (int p = 0; p < 2; p++) begin
            pattern = (p == 0) ? 32'hf1e2_d3c4 : 32'h1234_5678; // top bits set, then clear.
            issue(make_instr(1'b0, 5'd0, base, pattern, LOAD_NONE, STORE_SW));
            for (int off = 0; off < 4; off++) begin
                issue(make_instr(1'b1, 5'd11, base + word_t'(off), 32'd0, LOAD_LB, STORE_NONE));
                issue(make_instr(1'b1, 5'd12, base + word_t'(off), 32'd0, LOAD_LBU, STORE_NONE));
            end
            for (int off = 0; off < 4; off += 2) begin
                issue(make_instr(1'b1, 5'd13, base + word_t'(off), 32'd0, LOAD_LH, STORE_NONE));
                issue(make_instr(1'b1, 5'd14, base + word_t'(off), 32'd0, LOAD_LHU, STORE_NONE));
            end
        end
        drain();
    endtask

    task automatic test_random();
        word_t r;
        word_t addr;
        // fill every word first so no load sees an unwritten location.
        for (int w = 0; w < RAM_WORDS; w++) begin
            issue(make_instr(1'b0, 5'd0, word_t'(w * 4), $random(seed), LOAD_NONE, STORE_SW));
        end
        for (int n = 0; n < 200; n++) begin
            r    = $random(seed);
            addr = (r >> 3) % word_t'(RAM_WORDS * 4);
            case (r[2:0])
                3'd0: issue(make_instr(1'b0, 5'd0, addr, $random(seed), LOAD_NONE, STORE_SB));
                3'd1: issue(make_instr(1'b0, 5'd0, addr & ~32'd1, $random(seed),
                                       LOAD_NONE, STORE_SH));
                3'd2: issue(make_instr(1'b0, 5'd0, addr & ~32'd3, $random(seed),
                                       LOAD_NONE, STORE_SW));
                3'd3: issue(make_instr(1'b1, r[17:13], addr, 32'd0, LOAD_LB, STORE_NONE));
                3'd4: issue(make_instr(1'b1, r[17:13], addr, 32'd0, LOAD_LBU, STORE_NONE));
                3'd5: issue(make_instr(1'b1, r[17:13], addr & ~32'd1, 32'd0,
                                       LOAD_LH, STORE_NONE));
                3'd6: issue(make_instr(1'b1, r[17:13], addr & ~32'd1, 32'd0,
                                       LOAD_LHU, STORE_NONE));
                default: issue(make_instr(1'b1, r[17:13], addr & ~32'd3, 32'd0,
                                          LOAD_LW, STORE_NONE));
            endcase
        end
        drain();
    endtask

    initial begin
        bit reset_ok;
        errors  = 0;
        checks  = 0;
        seed    = 32'h95dd_4708;
        stage_i = '0;
        test_reset(reset_ok);
        if (reset_ok) begin
            test_alu_writeback();
            test_word_store_load();
            test_partial_stores();
            test_load_extend();
            test_random();
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage #(
    parameter int RAM_WORDS = 256
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  pipe_pkg::stage_in_t stage_i,
    output pipe_pkg::wb_bus_t   wb_o
);
    import lsu_pkg::*;
    import pipe_pkg::*;

    localparam int RAM_AW = $clog2(RAM_WORDS);

    logic [RAM_AW-1:0] word_addr;
    logic [1:0]        addr_lsb;
    logic              is_load;
    byte_en_t          byte_en;
    word_t             lane_wdata;
    word_t             rdata;
    word_t             load_word;

    assign word_addr = stage_i.alu_result[RAM_AW+1:2];
    assign addr_lsb  = stage_i.alu_result[1:0];
    assign is_load   = |stage_i.load_type; // any load type writes memory data.

    store_align store_align_i (
        .clk          (clk),
        .store_type_i (stage_i.store_type),
        .addr_lsb_i   (addr_lsb),
        .store_data_i (stage_i.store_data),
        .byte_en_o    (byte_en),
        .lane_wdata_o (lane_wdata)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) data_ram_i (
        .clk         (clk),
        .we_i        (stage_i.mem_wen),
        .word_addr_i (word_addr),
        .byte_en_i   (byte_en),
        .wdata_i     (lane_wdata),
        .rdata_o     (rdata)
    );

    load_extend load_extend_i (
        .clk         (clk),
        .load_type_i (stage_i.load_type),
        .addr_lsb_i  (addr_lsb),
        .rdata_i     (rdata),
        .load_word_o (load_word)
    );

    wb_reg wb_reg_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .rd_wen_i     (stage_i.rd_wen),
        .rd_idx_i     (stage_i.rd_idx),
        .is_load_i    (is_load),
        .alu_result_i (stage_i.alu_result),
        .load_word_i  (load_word),
        .csr_wdata_i  (stage_i.csr_wdata),
        .wb_o         (wb_o)
    );

endmodule

/* verilog/wb_reg.sv */
`timescale 1ns/1ps

module wb_reg (
    input  logic                           clk,
    input  logic                           arst_n_i,
    input  logic                           rd_wen_i,
    input  logic [pipe_pkg::REG_IDX_W-1:0] rd_idx_i,
    input  logic                           is_load_i,
    input  pipe_pkg::word_t                alu_result_i,
    input  pipe_pkg::word_t                load_word_i,
    input  pipe_pkg::word_t                csr_wdata_i,
    output pipe_pkg::wb_bus_t              wb_o
);
    import pipe_pkg::*;

    word_t wdata_sel;

    assign wdata_sel = is_load_i ? load_word_i : alu_result_i;

    // whole bundle clears on reset, register file sees wen low and zero data.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_o <= '0;
        end else begin
            wb_o.wen       <= rd_wen_i;
            wb_o.rd_idx    <= rd_idx_i;
            wb_o.wdata     <= wdata_sel;
            wb_o.csr_wdata <= csr_wdata_i; // csr value passes through.
        end
    end

endmodule

/* verilog/load_extend.sv */
`timescale 1ns/1ps

module load_extend (
    input  logic                clk,         // assertion sampling only.
    input  lsu_pkg::load_type_e load_type_i,
    input  logic [1:0]          addr_lsb_i,
    input  pipe_pkg::word_t     rdata_i,
    output pipe_pkg::word_t     load_word_o
);
    import lsu_pkg::*;
    import pipe_pkg::*;

    word_t      shifted;
    logic [2:0] nbytes;

    assign nbytes  = load_bytes(load_type_i);
    assign shifted = rdata_i >> {addr_lsb_i, 3'b000}; // addressed lane down to bit 0.

    always_comb begin
        case (load_type_i)
            LOAD_LB: begin
                load_word_o = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            end
            LOAD_LH: begin
                load_word_o = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            end
            LOAD_LBU: begin
                load_word_o = {{(XLEN-8){1'b0}}, shifted[7:0]};
            end
            LOAD_LHU: begin
                load_word_o = {{(XLEN-16){1'b0}}, shifted[15:0]};
            end
            LOAD_LW: begin
                load_word_o = rdata_i;
            end
            default: begin
                load_word_o = '0; // no load.
            end
        endcase
    end

    a_load_aligned: assert property (
        @(posedge clk) !misaligned(nbytes, addr_lsb_i)
    ) else $error("misaligned load, type %s offset %0d",
                  load_type_i.name(), addr_lsb_i);

endmodule

/* verilog/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         we_i,
    input  logic [$clog2(RAM_WORDS)-1:0] word_addr_i,
    input  lsu_pkg::byte_en_t            byte_en_i,
    input  pipe_pkg::word_t              wdata_i,
    output pipe_pkg::word_t              rdata_o
);
    import lsu_pkg::*;
    import pipe_pkg::*;

    word_t mem [RAM_WORDS];

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int i = 0; i < BYTE_LANES; i++) begin
                if (byte_en_i[i]) begin
                    mem[word_addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
        end
    end

    assign rdata_o = mem[word_addr_i]; // async read, new data visible next cycle.

    // a store strobe without lanes means the strobe and the store type disagree.
    a_we_has_lanes: assert property (
        @(posedge clk) we_i |-> (byte_en_i != '0)
    ) else $error("write strobe with no byte enables at word %0d", word_addr_i);

endmodule

/* verilog/store_align.sv */
`timescale 1ns/1ps

module store_align (
    input  logic                 clk,          // assertion sampling only.
    input  lsu_pkg::store_type_e store_type_i,
    input  logic [1:0]           addr_lsb_i,
    input  pipe_pkg::word_t      store_data_i,
    output lsu_pkg::byte_en_t    byte_en_o,
    output pipe_pkg::word_t      lane_wdata_o
);
    import lsu_pkg::*;

    logic [2:0] nbytes;

    assign nbytes    = store_bytes(store_type_i);
    assign byte_en_o = lane_mask(nbytes, addr_lsb_i); // zero for STORE_NONE.

    // copy the low byte or halfword into every lane, enables pick the right one.
    always_comb begin
        case (store_type_i)
            STORE_SB: lane_wdata_o = {BYTE_LANES{store_data_i[7:0]}};
            STORE_SH: lane_wdata_o = {(BYTE_LANES/2){store_data_i[15:0]}};
            default:  lane_wdata_o = store_data_i;
        endcase
    end

    // the ram has no misaligned support, the address must fit the size.
    a_store_aligned: assert property (
        @(posedge clk) !misaligned(nbytes, addr_lsb_i)
    ) else $error("misaligned store, type %s offset %0d",
                  store_type_i.name(), addr_lsb_i);

endmodule

/* verilog/pipe_pkg.sv */
package pipe_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0] word_t;

    // one instruction's result coming out of execute.
    typedef struct packed {
        logic                   rd_wen;
        logic [REG_IDX_W-1:0]   rd_idx;
        word_t                  alu_result; // also the memory address.
        word_t                  store_data;
        lsu_pkg::load_type_e    load_type;
        lsu_pkg::store_type_e   store_type;
        logic                   mem_wen;    // store strobe.
        word_t                  csr_wdata;
    } stage_in_t;

    // registered bundle toward the register file.
    typedef struct packed {
        logic                   wen;
        logic [REG_IDX_W-1:0]   rd_idx;
        word_t                  wdata;
        word_t                  csr_wdata;
    } wb_bus_t;

endpackage

/* verilog/lsu_pkg.sv */
package lsu_pkg;

    // load ops; nonzero means memory data goes to rd.
    typedef enum logic [2:0] {
        LOAD_NONE = 3'd0,
        LOAD_LB   = 3'd1,
        LOAD_LH   = 3'd2,
        LOAD_LW   = 3'd3,
        LOAD_LBU  = 3'd4,
        LOAD_LHU  = 3'd5
    } load_type_e;

    typedef enum logic [1:0] {
        STORE_NONE = 2'd0,
        STORE_SB   = 2'd1,
        STORE_SH   = 2'd2,
        STORE_SW   = 2'd3
    } store_type_e;

    localparam int BYTE_LANES = 4;

    typedef logic [BYTE_LANES-1:0] byte_en_t;

    // access size in bytes, 0 when no access.
    function automatic logic [2:0] store_bytes(store_type_e t);
        case (t)
            STORE_SB: return 3'd1;
            STORE_SH: return 3'd2;
            STORE_SW: return 3'd4;
            default:  return 3'd0;
        endcase
    endfunction

    function automatic logic [2:0] load_bytes(load_type_e t);
        case (t)
            LOAD_LB, LOAD_LBU: return 3'd1;
            LOAD_LH, LOAD_LHU: return 3'd2;
            LOAD_LW:           return 3'd4;
            default:           return 3'd0;
        endcase
    endfunction

    // lanes covered by an access of nbytes at offset off.
    function automatic byte_en_t lane_mask(logic [2:0] nbytes, logic [1:0] off);
        byte_en_t base;
        base = byte_en_t'((5'd1 << nbytes) - 5'd1);
        return byte_en_t'(base << off);
    endfunction

    // halfword on odd offset or word on any nonzero offset.
    function automatic logic misaligned(logic [2:0] nbytes, logic [1:0] off);
        return ((nbytes == 3'd2) && off[0]) || ((nbytes == 3'd4) && (off != 2'd0));
    endfunction

endpackage
